/* design/log_pkg.sv */
package log_pkg;

    localparam int FIX_W = 24;            // accumulator and mantissa width
    localparam int FRAC_W = 20;           // y is 4.20 fixed point
    localparam int MAX_EXP = 9;           // largest unbiased exponent handled
    localparam int NUM_ITER = 7;          // normalization steps, k = 1..7
    localparam logic [7:0] EXP_BIAS = 8'd127;
    localparam logic [FIX_W-1:0] X_ONE = 24'h800000;   // 1.0 in the x domain
    localparam logic [31:0] ERR_WORD = 32'hffff_ffff;

    typedef enum logic [1:0]
    {
        LOG_10 = 2'd0,
        LOG_E = 2'd1,
        LOG_2 = 2'd2,
        LOG_2_ALT = 2'd3                  // handled as base 2
    } log_base_e;

    // log of 2 per base, 4.20 format
    localparam logic [FIX_W-1:0] LOG_OF_TWO [0:2] = '{
        24'h04d105,                       // log10(2)
        24'h0b1721,                       // ln(2)
        24'h100000                        // log2(2)
    };

    // log(1 + 2^-k) per base, k = 1..7
    localparam logic [FIX_W-1:0] LOG_STEP [0:2][1:7] = '{
        '{
            24'h02d145,                   // log10(3/2)
            24'h018cf2,
            24'h00d185,
            24'h006bd8,
            24'h0036bd,
            24'h001b94,
            24'h000dd8                    // log10(129/128)
        },
        '{
            24'h067cc9,                   // ln(3/2)
            24'h0391ff,
            24'h01e270,
            24'h00f852,
            24'h007e0a,
            24'h003f81,
            24'h001fe0                    // ln(129/128)
        },
        '{
            24'h095c02,                   // log2(3/2)
            24'h05269e,
            24'h02b803,
            24'h01663f,
            24'h00b5d7,
            24'h005b9e,
            24'h002dfd                    // log2(129/128)
        }
    };

    typedef struct packed
    {
        log_base_e base;
        logic [31:0] operand;             // single-precision float
    } log_req_t;

    typedef struct packed
    {
        log_base_e base;
        logic [FIX_W-1:0] x;              // mantissa being driven towards 1.0
        logic [FIX_W-1:0] y;              // log accumulator, 4.20
        logic err;                        // operand out of range
    } log_work_t;

    typedef struct packed
    {
        logic [31:0] result;
    } log_rsp_t;

    // table row for a base, the spare code folds onto base 2
    function automatic logic [1:0] base_row(input log_base_e base);
        logic [1:0] row;
        if (base == LOG_2_ALT)
        begin
            row = 2'd2;
        end
        else
        begin
            row = base;
        end
        return row;
    endfunction

endpackage

/* design/log_credit_ctrl.sv */
module log_credit_ctrl #(
    parameter int CREDITS = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  logic credit_return,
    output logic in_ready,
    output logic accept
);

    localparam int CNT_W = $clog2(CREDITS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CREDITS);

    logic [CNT_W-1:0] credit_cnt;         // results the consumer can still take

    assign in_ready = (credit_cnt != '0);
    assign accept = in_valid && in_ready;

    // take and return in the same cycle cancel out
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            credit_cnt <= CNT_MAX;
        end
        else if (accept && !credit_return)
        begin
            credit_cnt <= credit_cnt - 1'b1;
        end
        else if (credit_return && !accept && (credit_cnt != CNT_MAX))
        begin
            credit_cnt <= credit_cnt + 1'b1;  // never above the granted count
        end
    end

endmodule

/* design/log_range_reduce.sv */
module log_range_reduce (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_accept,
    input  log_pkg::log_req_t   in_req,
    output logic                out_valid,
    output log_pkg::log_work_t  out_work
);

    logic [7:0] exp_unb;                  // unbiased exponent, wraps below 127
    logic [1:0] row;
    logic [log_pkg::FIX_W-1:0] scale;
    log_pkg::log_work_t work_next;

    always_comb
    begin
        exp_unb = in_req.operand[30:23] - log_pkg::EXP_BIAS;
        row = log_pkg::base_row(in_req.base);
        scale = exp_unb[3:0] + 1'b1;      // e + 1, the mantissa shift adds one

        work_next.base = in_req.base;
        work_next.err = in_req.operand[31] || (exp_unb > log_pkg::MAX_EXP);
        // hidden one restored, then halved so x starts below 1.0
        work_next.x = {1'b1, in_req.operand[22:0]} >> 1;
        work_next.y = scale * log_pkg::LOG_OF_TWO[row];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_accept;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_accept)
        begin
            out_work <= work_next;
        end
    end

endmodule

/* design/log_norm_stage.sv */
module log_norm_stage #(
    parameter int STEP_K = 1
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  log_pkg::log_work_t  in_work,
    output logic                out_valid,
    output log_pkg::log_work_t  out_work
);

    logic [1:0] row;
    logic [log_pkg::FIX_W-1:0] x_sum;     // x * (1 + 2^-k)
    logic take;
    log_pkg::log_work_t work_next;

    always_comb
    begin
        row = log_pkg::base_row(in_work.base);
        x_sum = in_work.x + (in_work.x >> STEP_K);
        take = !in_work.err && (x_sum < log_pkg::X_ONE);   // only while x stays below 1.0

        work_next = in_work;
        if (take)
        begin
            work_next.x = x_sum;
            work_next.y = in_work.y - log_pkg::LOG_STEP[row][STEP_K];
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            out_work <= work_next;
        end
    end

endmodule

/* design/log_result_pack.sv */
module log_result_pack (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  log_pkg::log_work_t  in_work,
    output logic                out_valid,
    output log_pkg::log_rsp_t   out_rsp
);

    logic [log_pkg::FIX_W-1:0] y_corr;    // y after the residual correction
    logic [log_pkg::FIX_W-1:0] y_norm;    // leading one moved to bit 20
    logic [4:0] lz;                       // leading zeros of y_corr, 24 when zero
    logic [7:0] exp_out;
    log_pkg::log_rsp_t rsp_next;

    // residual 1 - x approximates the remaining log, applied unscaled
    always_comb
    begin
        y_corr = in_work.y - ((log_pkg::X_ONE - in_work.x) >> 3);
    end

    // last hit wins, so the highest set bit sets the count
    always_comb
    begin
        lz = 5'd24;
        for (int i = 0; i < log_pkg::FIX_W; i++)
        begin
            if (y_corr[i])
            begin
                lz = 5'(log_pkg::FIX_W - 1 - i);
            end
        end
    end

    always_comb
    begin
        if (lz <= 5'd3)
        begin
            y_norm = y_corr >> (5'd3 - lz);
        end
        else
        begin
            y_norm = y_corr << (lz - 5'd3);
        end
        exp_out = 8'd130 - {3'b000, lz};  // bias plus the 3 integer bits

        if (in_work.err)
        begin
            rsp_next.result = log_pkg::ERR_WORD;
        end
        else if (y_corr == '0)
        begin
            rsp_next.result = 32'd0;
        end
        else
        begin
            rsp_next.result = {1'b0, exp_out, y_norm[log_pkg::FRAC_W-1:0], 3'b000};
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            out_rsp <= rsp_next;
        end
    end

endmodule

/* design/log_unit_top.sv */
module log_unit_top #(
    parameter int CREDITS = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  log_pkg::log_req_t   in_req,
    output logic                in_ready,
    output logic                out_valid,
    output log_pkg::log_rsp_t   out_rsp,
    input  logic                credit_return
);

    logic accept;                         // request taken this cycle

    // link n feeds normalization step n + 1, the last link feeds the packer
    logic [log_pkg::NUM_ITER:0] link_valid;
    log_pkg::log_work_t link_work [log_pkg::NUM_ITER+1];

    log_credit_ctrl #(
        .CREDITS        (CREDITS)
    ) credit_ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .credit_return  (credit_return),
        .in_ready       (in_ready),
        .accept         (accept)
    );

    log_range_reduce range_reduce_i (
        .clk            (clk),
        .reset          (reset),
        .in_accept      (accept),
        .in_req         (in_req),
        .out_valid      (link_valid[0]),
        .out_work       (link_work[0])
    );

    generate
        for (genvar i = 0; i < log_pkg::NUM_ITER; i++)
        begin : g_norm
            log_norm_stage #(
                .STEP_K     (i + 1)
            ) norm_stage_i (
                .clk        (clk),
                .reset      (reset),
                .in_valid   (link_valid[i]),
                .in_work    (link_work[i]),
                .out_valid  (link_valid[i+1]),
                .out_work   (link_work[i+1])
            );
        end
    endgenerate

    log_result_pack result_pack_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (link_valid[log_pkg::NUM_ITER]),
        .in_work        (link_work[log_pkg::NUM_ITER]),
        .out_valid      (out_valid),
        .out_rsp        (out_rsp)
    );

endmodule

/* dv/log_unit_model.svh */
`ifndef LOG_UNIT_MODEL_SVH
`define LOG_UNIT_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'h5898_c7a6;

// x^32 + x^22 + x^2 + x + 1, the new bit enters at bit 0
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// code 3 shares the base 2 constants
function automatic int table_row(input logic [1:0] base);
    int row;
    if (base == 2'd3)
    begin
        row = 2;
    end
    else
    begin
        row = int'(base);
    end
    return row;
endfunction

// expected result word for one request
function automatic logic [31:0] model_log(input logic [1:0] base, input logic [31:0] operand);
    logic [7:0] e;
    logic [23:0] x;
    logic [23:0] x_next;
    logic [23:0] y;
    logic [23:0] mant;
    logic [31:0] result;
    int row;
    int k;
    int p;
    e = operand[30:23] - 8'd127;          // wraps for operands below 1.0
    row = table_row(base);
    if (operand[31] || (e > 8'd9))
    begin
        result = 32'hffff_ffff;
    end
    else
    begin
        x = {1'b1, operand[22:0]} >> 1;   // mantissa / 2, so (e + 1) powers of two go to y
        y = 24'((int'(e) + 1) * int'(log_pkg::LOG_OF_TWO[row]));
        for (k = 1; k <= 7; k++)
        begin
            x_next = x + (x >> k);
            if (x_next < 24'h80_0000)
            begin
                x = x_next;
                y = y - log_pkg::LOG_STEP[row][k];
            end
        end
        y = y - ((24'h80_0000 - x) >> 3); // residual 1 - x, same weight in every base
        if (y == 24'd0)
        begin
            result = 32'd0;
        end
        else
        begin
            p = 23;
            while (!y[p])
            begin
                p--;
            end
            if (p >= 20)
            begin
                mant = y >> (p - 20);
            end
            else
            begin
                mant = y << (20 - p);
            end
            result = {1'b0, 8'(107 + p), mant[19:0], 3'b000};   // leading one at bit p
        end
    end
    return result;
endfunction

`endif

/* dv/log_unit_tb.sv */
module log_unit_tb;

    localparam int CREDITS = 4;
    localparam int LATENCY = 9;               // accept edge to the edge that takes the result
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_COUNT = 64;

    // 1.0, 2.0, 10.0, 100.0, 1000.0
    localparam logic [31:0] DIRECTED_OPS [0:4] = '{
        32'h3f80_0000, 32'h4000_0000, 32'h4120_0000, 32'h42c8_0000, 32'h447a_0000
    };
    // -1.0, -0.0, -10.0, 0.0, 0.5, just below 1.0, 1024.0, infinity
    localparam logic [31:0] ERROR_OPS [0:7] = '{
        32'hbf80_0000, 32'h8000_0000, 32'hc120_0000, 32'h0000_0000,
        32'h3f00_0000, 32'h3f7f_ffff, 32'h4480_0000, 32'h7f80_0000
    };

    `include "log_unit_model.svh"

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic in_valid = 1'b0;
    log_pkg::log_req_t in_req = '0;
    logic in_ready;
    logic out_valid;
    log_pkg::log_rsp_t out_rsp;
    logic credit_return = 1'b0;

    logic want_accuracy = 1'b0;               // tag for the request on in_req
    logic hold_credits = 1'b0;                // consumer keeps its credits
    int extra_credits = 0;                    // credits released while holding
    int extra_used = 0;
    int held_credits = 0;                     // results whose credit is not yet returned
    int in_flight = 0;
    int results_seen = 0;
    int cycle_cnt = 0;
    logic [31:0] lfsr_state = LFSR_SEED;

    logic [31:0] exp_result_q [$];
    logic [31:0] operand_q [$];
    logic [1:0] base_q [$];
    int accept_cycle_q [$];
    logic accuracy_q [$];

    log_unit_top #(
        .CREDITS        (CREDITS)
    ) dut_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_req         (in_req),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_rsp        (out_rsp),
        .credit_return  (credit_return)
    );

    initial
    begin
        forever
        begin
            #50 clk = ~clk;
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("error at %0t: %s, got 0x%h, expected 0x%h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping after the first error");
        end
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
        begin
            report_failure($sformatf("simulation hung, still running after %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    function automatic real float_value(input logic [31:0] bits);
        real v;
        int e;
        v = 1.0 + real'(bits[22:0]) / 8388608.0;
        e = int'(bits[30:23]) - 127;
        if (bits[30:0] == 31'd0)
        begin
            v = 0.0;
        end
        while (e > 0)
        begin
            v = v * 2.0;
            e--;
        end
        while (e < 0)
        begin
            v = v / 2.0;
            e++;
        end
        return v;
    endfunction

    function automatic real real_log(input logic [1:0] base, input logic [31:0] operand);
        real l;
        l = $ln(float_value(operand));
        if (base == 2'd0)
        begin
            l = l / $ln(10.0);
        end
        else if (base != 2'd1)
        begin
            l = l / $ln(2.0);
        end
        return l;
    endfunction

    // results are compared in arrival order against what was accepted
    always @(posedge clk)
    begin : scoreboard
        int held_now;
        real diff;
        logic [31:0] expected;
        logic [31:0] operand;
        logic [1:0] base;
        int accept_cycle;
        if (out_valid)
        begin
            if (exp_result_q.size() == 0)
            begin
                report_failure("a result arrived with no request outstanding");
            end
            else
            begin
                expected = exp_result_q.pop_front();
                operand = operand_q.pop_front();
                base = base_q.pop_front();
                accept_cycle = accept_cycle_q.pop_front();
                check_equal(out_rsp.result, expected,
                            $sformatf("result for operand %h base %0d", operand, base));
                check_equal(cycle_cnt - accept_cycle, LATENCY, "cycles from accept to result");
                if (accuracy_q.pop_front())
                begin
                    diff = float_value(out_rsp.result) - real_log(base, operand);
                    check_equal((diff <= 0.03125) && (diff >= -0.03125), 1'b1,
                                $sformatf("distance to real log, operand %h base %0d",
                                          operand, base));
                end
            end
        end
        if (in_valid && in_ready)
        begin
            exp_result_q.push_back(model_log(in_req.base, in_req.operand));
            operand_q.push_back(in_req.operand);
            base_q.push_back(in_req.base);
            accept_cycle_q.push_back(cycle_cnt);
            accuracy_q.push_back(want_accuracy);
        end
        in_flight <= in_flight + int'(in_valid && in_ready) - int'(out_valid);
        results_seen <= results_seen + int'(out_valid);

        held_now = held_credits + int'(out_valid);
        if ((held_now > 0) && (!hold_credits || (extra_used < extra_credits)))
        begin
            credit_return <= 1'b1;            // one credit back per cycle
            held_credits <= held_now - 1;
            if (hold_credits)
            begin
                extra_used <= extra_used + 1;
            end
        end
        else
        begin
            credit_return <= 1'b0;
            held_credits <= held_now;
        end
    end

    function automatic log_pkg::log_req_t make_req(input logic [1:0] base,
                                                   input logic [31:0] operand);
        log_pkg::log_req_t req;
        req.base = log_pkg::log_base_e'(base);
        req.operand = operand;
        return req;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // holds the request until the edge that accepts it
    task automatic send_request(input logic [1:0] base, input logic [31:0] operand,
                                input logic accuracy);
        logic taken;
        in_valid <= 1'b1;
        in_req <= make_req(base, operand);
        want_accuracy <= accuracy;
        taken = 1'b0;
        while (!taken)
        begin
            @(posedge clk);
            taken = in_ready;
        end
        in_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while ((in_flight != 0) || (held_credits != 0) || credit_return)
        begin
            @(posedge clk);
        end
    endtask

    task automatic check_reset_state();
        check_equal(out_valid, 1'b0, "out_valid after reset");
        check_equal(in_ready, 1'b1, "in_ready after reset");
    endtask

    task automatic directed_bases();
        int b;
        int n;
        for (b = 0; b < 3; b++)
        begin
            for (n = 0; n < 5; n++)
            begin
                // log(1.0) is zero and the residual may take y just below it, where it wraps
                send_request(2'(b), DIRECTED_OPS[n], n != 0);
            end
        end
        wait_idle();
    endtask

    task automatic random_operands();
        logic [31:0] e_bits;
        logic [31:0] frac;
        logic [31:0] base;
        int i;
        for (i = 0; i < RANDOM_COUNT; i++)
        begin
            random_bits(4, e_bits);
            random_bits(23, frac);
            random_bits(2, base);
            send_request(base[1:0], {1'b0, 8'(127 + e_bits % 10), frac[22:0]}, 1'b0);
        end
        wait_idle();
    endtask

    task automatic error_operands();
        int n;
        for (n = 0; n < 8; n++)
        begin
            check_equal(model_log(2'(n % 4), ERROR_OPS[n]), 32'hffff_ffff, "error word rule");
            send_request(2'(n % 4), ERROR_OPS[n], 1'b0);
        end
        wait_idle();
    endtask

    task automatic back_to_back_order();
        int i;
        for (i = 0; i < 12; i++)
        begin
            send_request(2'(i % 3), {1'b0, 8'(127 + i % 10), 23'(i * 32'h0005_a5a5)}, 1'b0);
        end
        wait_idle();
    endtask

    task automatic credit_back_pressure();
        int accepts;
        int seen_before;
        int i;
        hold_credits <= 1'b1;
        seen_before = results_seen;
        accepts = 0;
        in_valid <= 1'b1;
        for (i = 0; i < CREDITS + 12; i++)
        begin
            in_req <= make_req(2'(i % 4), 32'h4120_0000 + (i << 16));
            @(posedge clk);
            if (in_ready)
            begin
                accepts++;
            end
        end
        check_equal(accepts, CREDITS, "accepts with no credit returned");
        check_equal(in_ready, 1'b0, "in_ready with all credits spent");
        check_equal(results_seen - seen_before, CREDITS, "results with no credit returned");

        extra_credits <= extra_credits + 1;  // hand back a single credit
        accepts = 0;
        for (i = 0; i < 8; i++)
        begin
            @(posedge clk);
            if (in_ready)
            begin
                accepts++;
            end
        end
        check_equal(accepts, 1, "accepts after one returned credit");
        in_valid <= 1'b0;
        hold_credits <= 1'b0;
        wait_idle();
    endtask

    initial
    begin
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_reset_state();
        directed_bases();
        random_operands();
        error_operands();
        back_to_back_order();
        credit_back_pressure();
        $display("TEST OK");
        $finish;
    end

endmodule

/* compile.f */
+incdir+dv
design/log_pkg.sv
design/log_credit_ctrl.sv
design/log_range_reduce.sv
design/log_norm_stage.sv
design/log_result_pack.sv
design/log_unit_top.sv
dv/log_unit_tb.sv
